// ==== common/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data and address width of the core
`define XLEN 32

// Shared word memory geometry
`define MEM_WORDS 1024
`define MEM_ADDR_BITS 10

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== common/rvIsaPkg.sv ====
package rvIsaPkg;

    // Base opcodes of the supported RV32I subset
    localparam logic [6:0] opcodeOp     = 7'b0110011;
    localparam logic [6:0] opcodeOpImm  = 7'b0010011;
    localparam logic [6:0] opcodeLui    = 7'b0110111;
    localparam logic [6:0] opcodeLoad   = 7'b0000011;
    localparam logic [6:0] opcodeStore  = 7'b0100011;
    localparam logic [6:0] opcodeBranch = 7'b1100011;
    localparam logic [6:0] opcodeJal    = 7'b1101111;
    localparam logic [6:0] opcodeJalr   = 7'b1100111;

    // ALU operations, passB forwards the second operand for lui
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluPassB
    } aluOpT;

    // Instruction classes seen by the sequencer and execute unit
    typedef enum logic [2:0] {
        classRegOp,
        classImmOp,
        classLui,
        classLoad,
        classStore,
        classBranch,
        classJal,
        classJalr
    } instrClassT;

    // Write-back source
    typedef enum logic [1:0] {
        resultAlu,
        resultMemory,
        resultPcPlus4
    } resultSrcT;

endpackage

// ==== common/memBusPkg.sv ====
package memBusPkg;

    // Peers of the shared memory
    // Listed in priority order, highest first
    typedef enum logic [1:0] {
        reqLsu,
        reqHost,
        reqFetch
    } requesterT;

endpackage

// ==== core/instructionDecoder.sv ====
`include "core_settings.svh"

module instructionDecoder (
    input  logic [`XLEN-1:0]     instr,
    output logic [4:0]           rs1,
    output logic [4:0]           rs2,
    output logic [4:0]           rd,
    output logic [`XLEN-1:0]     immExt,
    output rvIsaPkg::instrClassT instrClass,
    output rvIsaPkg::aluOpT      aluOp,
    output logic                 aluSrc,
    output rvIsaPkg::resultSrcT  resultSrc,
    output logic                 writesRd,
    output logic                 branchNe
);
    import rvIsaPkg::*;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic             funct7b5;
    logic             functOk;
    logic [`XLEN-1:0] immI;
    logic [`XLEN-1:0] immS;
    logic [`XLEN-1:0] immB;
    logic [`XLEN-1:0] immJ;
    logic [`XLEN-1:0] immU;

    // ALU op from funct3, isSub only set for register ops
    function automatic aluOpT aluFromFunct3(input logic [2:0] f3, input logic isSub);
        case (f3)
            3'b000:  return isSub ? aluSub : aluAdd;
            3'b010:  return aluSlt;
            3'b100:  return aluXor;
            3'b110:  return aluOr;
            3'b111:  return aluAnd;
            default: return aluAdd;
        endcase
    endfunction

    // Field split and immediate formats
    always_comb begin
        opcode   = instr[6:0];
        funct3   = instr[14:12];
        funct7b5 = instr[30];
        rs1      = instr[19:15];
        rs2      = instr[24:20];
        rd       = instr[11:7];
        // Shifts and sltu are not supported
        functOk  = (funct3 != 3'b001) && (funct3 != 3'b011) && (funct3 != 3'b101);
        immI = {{(`XLEN-12){instr[31]}}, instr[31:20]};
        immS = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
        immB = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        immJ = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        immU = {instr[31:12], 12'b0};
    end

    // Control generation
    always_comb begin
        // Defaults form a no-operation
        instrClass = classImmOp;
        aluOp      = aluAdd;
        aluSrc     = 1'b0;
        resultSrc  = resultAlu;
        writesRd   = 1'b0;
        immExt     = immI;
        // beq is funct3 000, bne is 001
        branchNe   = funct3[0];
        case (opcode)
            opcodeOp: begin
                instrClass = classRegOp;
                aluOp      = aluFromFunct3(funct3, funct7b5);
                writesRd   = functOk;
            end
            opcodeOpImm: begin
                aluOp    = aluFromFunct3(funct3, 1'b0);
                aluSrc   = 1'b1;
                writesRd = functOk;
            end
            opcodeLui: begin
                instrClass = classLui;
                immExt     = immU;
                aluOp      = aluPassB;
                aluSrc     = 1'b1;
                writesRd   = 1'b1;
            end
            opcodeLoad: begin
                instrClass = classLoad;
                aluSrc     = 1'b1;
                resultSrc  = resultMemory;
                writesRd   = 1'b1;
            end
            opcodeStore: begin
                instrClass = classStore;
                immExt     = immS;
                aluSrc     = 1'b1;
            end
            opcodeBranch: begin
                instrClass = classBranch;
                immExt     = immB;
                aluOp      = aluSub;
            end
            opcodeJal: begin
                instrClass = classJal;
                immExt     = immJ;
                resultSrc  = resultPcPlus4;
                writesRd   = 1'b1;
            end
            opcodeJalr: begin
                instrClass = classJalr;
                resultSrc  = resultPcPlus4;
                writesRd   = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== core/registerFile.sv ====
`include "core_settings.svh"

module registerFile (
    input  logic             iClk,
    input  logic             rstN,
    input  logic             writeEn,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  logic [4:0]       rd,
    input  logic [`XLEN-1:0] writeData,
    output logic [`XLEN-1:0] rs1Data,
    output logic [`XLEN-1:0] rs2Data
);

    logic [`XLEN-1:0] regs [32];

    // Single write port, x0 never written
    always_ff @(posedge iClk) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (writeEn && (rd != 5'd0)) begin
            regs[rd] <= writeData;
        end
    end

    // Combinational reads with x0 forced to zero
    always_comb begin
        rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
        rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];
    end

endmodule

// ==== core/executeUnit.sv ====
`include "core_settings.svh"

module executeUnit (
    input  logic [`XLEN-1:0]     pc,
    input  logic [`XLEN-1:0]     rs1Data,
    input  logic [`XLEN-1:0]     rs2Data,
    input  logic [`XLEN-1:0]     immExt,
    input  rvIsaPkg::aluOpT      aluOp,
    input  logic                 aluSrc,
    input  rvIsaPkg::instrClassT instrClass,
    input  logic                 branchNe,
    output logic [`XLEN-1:0]     aluResult,
    output logic                 branchTaken,
    output logic [`XLEN-1:0]     targetPc
);
    import rvIsaPkg::*;

    logic [`XLEN-1:0] aluB;
    logic [`XLEN-1:0] jalrSum;
    logic             regsEqual;

    // ALU with immediate or register second operand
    always_comb begin
        aluB = aluSrc ? immExt : rs2Data;
        case (aluOp)
            aluSub:   aluResult = rs1Data - aluB;
            aluAnd:   aluResult = rs1Data & aluB;
            aluOr:    aluResult = rs1Data | aluB;
            aluXor:   aluResult = rs1Data ^ aluB;
            aluSlt:   aluResult = {{(`XLEN-1){1'b0}}, $signed(rs1Data) < $signed(aluB)};
            aluPassB: aluResult = aluB;
            default:  aluResult = rs1Data + aluB;
        endcase
    end

    // Branch decision, jumps always redirect
    always_comb begin
        regsEqual = rs1Data == rs2Data;
        case (instrClass)
            classBranch: branchTaken = regsEqual ^ branchNe;
            classJal:    branchTaken = 1'b1;
            classJalr:   branchTaken = 1'b1;
            default:     branchTaken = 1'b0;
        endcase
    end

    // Redirect target, jalr clears bit 0
    always_comb begin
        jalrSum  = rs1Data + immExt;
        targetPc = (instrClass == classJalr) ? {jalrSum[`XLEN-1:1], 1'b0} : pc + immExt;
    end

endmodule

// ==== core/fetchSequencer.sv ====
`include "core_settings.svh"

module fetchSequencer (
    input  logic                 iClk,
    input  logic                 rstN,
    input  logic                 run,
    input  logic                 fetchReady,
    input  logic                 fetchRspValid,
    input  logic [`XLEN-1:0]     fetchRdata,
    input  rvIsaPkg::instrClassT instrClass,
    input  logic                 branchTaken,
    input  logic [`XLEN-1:0]     targetPc,
    input  logic                 memDone,
    output logic                 fetchValid,
    output logic [`XLEN-1:0]     fetchAddr,
    output logic [`XLEN-1:0]     instr,
    output logic [`XLEN-1:0]     pc,
    output logic [`XLEN-1:0]     pcPlus4,
    output logic                 memStart,
    output logic                 regWrite,
    output logic                 retireValid
);
    import rvIsaPkg::*;

    typedef enum logic [2:0] {
        phaseIdle,
        phaseFetch,
        phaseWait,
        phaseExecute,
        phaseMemory
    } phaseT;

    phaseT            phase;
    logic             isMemOp;
    logic             commit;
    logic [`XLEN-1:0] nextPc;

    ////////////////////////////////////////////////////////////
    // Phase decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        isMemOp    = (instrClass == classLoad) || (instrClass == classStore);
        pcPlus4    = pc + `XLEN'(4);
        // Loads and stores never redirect, so this is pc+4 for them
        nextPc     = branchTaken ? targetPc : pcPlus4;
        // Non-memory ops commit in execute, memory ops at memDone
        commit     = ((phase == phaseExecute) && !isMemOp) || ((phase == phaseMemory) && memDone);
        fetchValid = phase == phaseFetch;
        fetchAddr  = pc;
        memStart   = (phase == phaseExecute) && isMemOp;
        regWrite   = commit;
        retireValid = commit;
    end

    ////////////////////////////////////////////////////////////
    // PC and phase register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge iClk) begin
        if (!rstN) begin
            phase <= phaseIdle;
            pc    <= `RESET_PC;
        end else begin
            case (phase)
                phaseIdle:    if (run) phase <= phaseFetch;
                // Held here while the arbiter back-pressures
                phaseFetch:   if (fetchReady) phase <= phaseWait;
                phaseWait:    if (fetchRspValid) phase <= phaseExecute;
                phaseExecute: if (isMemOp) phase <= phaseMemory;
                default:      phase <= phase;
            endcase
            if (commit) begin
                pc    <= nextPc;
                phase <= run ? phaseFetch : phaseIdle;
            end
        end
    end

    // Instruction register, loaded from the fetch response
    always_ff @(posedge iClk) begin
        if ((phase == phaseWait) && fetchRspValid) begin
            instr <= fetchRdata;
        end
    end

endmodule

// ==== core/loadStoreUnit.sv ====
`include "core_settings.svh"

module loadStoreUnit (
    input  logic             iClk,
    input  logic             rstN,
    input  logic             memStart,
    input  logic             isStore,
    input  logic [`XLEN-1:0] addr,
    input  logic [`XLEN-1:0] storeData,
    input  logic             lsuReady,
    input  logic             lsuRspValid,
    input  logic [`XLEN-1:0] lsuRdata,
    output logic             lsuValid,
    output logic [`XLEN-1:0] lsuAddr,
    output logic             lsuWrite,
    output logic [`XLEN-1:0] lsuWdata,
    output logic             memDone,
    output logic [`XLEN-1:0] loadData
);

    logic granted;

    ////////////////////////////////////////////////////////////
    // Request register, held from memStart until the grant
    ////////////////////////////////////////////////////////////

    always_ff @(posedge iClk) begin
        if (!rstN) begin
            lsuValid <= 1'b0;
            lsuAddr  <= '0;
            lsuWrite <= 1'b0;
            lsuWdata <= '0;
        end else if (memStart) begin
            lsuValid <= 1'b1;
            lsuAddr  <= addr;
            lsuWrite <= isStore;
            lsuWdata <= storeData;
        end else if (granted) begin
            lsuValid <= 1'b0;
        end
    end

    // A store ends at its grant, a load at its response
    always_comb begin
        granted  = lsuValid && lsuReady;
        memDone  = (granted && lsuWrite) || lsuRspValid;
        loadData = lsuRdata;
    end

endmodule

// ==== src/sharedMemory.sv ====
`include "core_settings.svh"

module sharedMemory #(
    parameter int memWords = `MEM_WORDS
) (
    input  logic             iClk,
    input  logic             rstN,
    input  logic             reqFetchValid,
    input  logic [`XLEN-1:0] reqFetchAddr,
    input  logic             reqFetchWrite,
    input  logic [`XLEN-1:0] reqFetchWdata,
    input  logic             reqLsuValid,
    input  logic [`XLEN-1:0] reqLsuAddr,
    input  logic             reqLsuWrite,
    input  logic [`XLEN-1:0] reqLsuWdata,
    input  logic             reqHostValid,
    input  logic [`XLEN-1:0] reqHostAddr,
    input  logic             reqHostWrite,
    input  logic [`XLEN-1:0] reqHostWdata,
    output logic             reqFetchReady,
    output logic             rspFetchValid,
    output logic [`XLEN-1:0] rspFetchRdata,
    output logic             reqLsuReady,
    output logic             rspLsuValid,
    output logic [`XLEN-1:0] rspLsuRdata,
    output logic             reqHostReady,
    output logic             rspHostValid,
    output logic [`XLEN-1:0] rspHostRdata
);
    import memBusPkg::*;

    logic [`XLEN-1:0]         mem [memWords];
    logic                     anyGrant;
    requesterT                grantId;
    logic [`XLEN-1:0]         selAddr;
    logic                     selWrite;
    logic [`XLEN-1:0]         selWdata;
    logic [`MEM_ADDR_BITS-1:0] wordAddr;
    logic                     rspPending;
    requesterT                rspOwner;
    logic [`XLEN-1:0]         rdataQ;

    ////////////////////////////////////////////////////////////
    // Fixed-priority grant, lsu then host then fetch
    ////////////////////////////////////////////////////////////

    always_comb begin
        reqLsuReady   = reqLsuValid;
        reqHostReady  = reqHostValid && !reqLsuValid;
        reqFetchReady = reqFetchValid && !reqLsuValid && !reqHostValid;
        anyGrant      = reqLsuValid || reqHostValid || reqFetchValid;
        if (reqLsuValid) begin
            grantId  = reqLsu;
            selAddr  = reqLsuAddr;
            selWrite = reqLsuWrite;
            selWdata = reqLsuWdata;
        end else if (reqHostValid) begin
            grantId  = reqHost;
            selAddr  = reqHostAddr;
            selWrite = reqHostWrite;
            selWdata = reqHostWdata;
        end else begin
            grantId  = reqFetch;
            selAddr  = reqFetchAddr;
            selWrite = reqFetchWrite;
            selWdata = reqFetchWdata;
        end
        // Byte address to word index
        wordAddr = selAddr[`MEM_ADDR_BITS+1:2];
    end

    ////////////////////////////////////////////////////////////
    // Word array, accessed at the grant
    ////////////////////////////////////////////////////////////

    always_ff @(posedge iClk) begin
        if (anyGrant) begin
            if (selWrite) begin
                mem[wordAddr] <= selWdata;
            end else begin
                rdataQ <= mem[wordAddr];
            end
        end
    end

    // Remember who gets the read response next cycle
    always_ff @(posedge iClk) begin
        if (!rstN) begin
            rspPending <= 1'b0;
            rspOwner   <= reqFetch;
        end else begin
            rspPending <= anyGrant && !selWrite;
            rspOwner   <= grantId;
        end
    end

    // Response steering, data is shared by all peers
    always_comb begin
        rspLsuValid   = rspPending && (rspOwner == reqLsu);
        rspHostValid  = rspPending && (rspOwner == reqHost);
        rspFetchValid = rspPending && (rspOwner == reqFetch);
        rspLsuRdata   = rdataQ;
        rspHostRdata  = rdataQ;
        rspFetchRdata = rdataQ;
    end

endmodule

// ==== src/socTop.sv ====
`include "core_settings.svh"

module socTop (
    input  logic             iClk,
    input  logic             rstN,
    input  logic             run,
    input  logic             hostValid,
    input  logic             hostWrite,
    input  logic [`XLEN-1:0] hostAddr,
    input  logic [`XLEN-1:0] hostWdata,
    output logic             hostReady,
    output logic             hostRspValid,
    output logic [`XLEN-1:0] hostRdata,
    output logic             retireValid,
    output logic [`XLEN-1:0] retirePc,
    output logic [`XLEN-1:0] retireData
);
    import rvIsaPkg::*;

    // Fetch side
    logic             fetchValid;
    logic             fetchReady;
    logic             fetchRspValid;
    logic [`XLEN-1:0] fetchAddr;
    logic [`XLEN-1:0] fetchRdata;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pcPlus4;
    logic             memStart;
    logic             memDone;
    logic             regWrite;

    // Decode
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [4:0]       rd;
    logic [`XLEN-1:0] immExt;
    instrClassT       instrClass;
    aluOpT            aluOp;
    logic             aluSrc;
    resultSrcT        resultSrc;
    logic             writesRd;
    logic             branchNe;

    // Register file and execute
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] writeBackData;
    logic             regWriteEn;
    logic [`XLEN-1:0] aluResult;
    logic             branchTaken;
    logic [`XLEN-1:0] targetPc;

    // Load/store side
    logic             isStore;
    logic             lsuValid;
    logic             lsuReady;
    logic             lsuWrite;
    logic             lsuRspValid;
    logic [`XLEN-1:0] lsuAddr;
    logic [`XLEN-1:0] lsuWdata;
    logic [`XLEN-1:0] lsuRdata;
    logic [`XLEN-1:0] loadData;

    ////////////////////////////////////////////////////////////
    // Write-back select and retire trace
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (resultSrc)
            resultMemory:  writeBackData = loadData;
            resultPcPlus4: writeBackData = pcPlus4;
            default:       writeBackData = aluResult;
        endcase
        // Commit strobe qualified by the decoded destination
        regWriteEn = regWrite && writesRd;
        isStore    = instrClass == classStore;
        retirePc   = pc;
        retireData = writeBackData;
    end

    ////////////////////////////////////////////////////////////
    // Core blocks
    ////////////////////////////////////////////////////////////

    fetchSequencer sequencer (
        .iClk(iClk), .rstN(rstN), .run(run),
        .fetchReady(fetchReady), .fetchRspValid(fetchRspValid), .fetchRdata(fetchRdata),
        .instrClass(instrClass), .branchTaken(branchTaken), .targetPc(targetPc),
        .memDone(memDone), .fetchValid(fetchValid), .fetchAddr(fetchAddr),
        .instr(instr), .pc(pc), .pcPlus4(pcPlus4), .memStart(memStart),
        .regWrite(regWrite), .retireValid(retireValid)
    );

    instructionDecoder decoder (
        .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .immExt(immExt),
        .instrClass(instrClass), .aluOp(aluOp), .aluSrc(aluSrc),
        .resultSrc(resultSrc), .writesRd(writesRd), .branchNe(branchNe)
    );

    registerFile regFile (
        .iClk(iClk), .rstN(rstN), .writeEn(regWriteEn),
        .rs1(rs1), .rs2(rs2), .rd(rd), .writeData(writeBackData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    executeUnit execute (
        .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data), .immExt(immExt),
        .aluOp(aluOp), .aluSrc(aluSrc), .instrClass(instrClass), .branchNe(branchNe),
        .aluResult(aluResult), .branchTaken(branchTaken), .targetPc(targetPc)
    );

    // Store data comes from rs2, the address from the ALU
    loadStoreUnit lsu (
        .iClk(iClk), .rstN(rstN), .memStart(memStart), .isStore(isStore),
        .addr(aluResult), .storeData(rs2Data),
        .lsuReady(lsuReady), .lsuRspValid(lsuRspValid), .lsuRdata(lsuRdata),
        .lsuValid(lsuValid), .lsuAddr(lsuAddr), .lsuWrite(lsuWrite),
        .lsuWdata(lsuWdata), .memDone(memDone), .loadData(loadData)
    );

    ////////////////////////////////////////////////////////////
    // Shared memory, fetch is read-only
    ////////////////////////////////////////////////////////////

    sharedMemory #(.memWords(`MEM_WORDS)) memory (
        .iClk(iClk), .rstN(rstN),
        .reqFetchValid(fetchValid), .reqFetchAddr(fetchAddr),
        .reqFetchWrite(1'b0), .reqFetchWdata('0),
        .reqLsuValid(lsuValid), .reqLsuAddr(lsuAddr),
        .reqLsuWrite(lsuWrite), .reqLsuWdata(lsuWdata),
        .reqHostValid(hostValid), .reqHostAddr(hostAddr),
        .reqHostWrite(hostWrite), .reqHostWdata(hostWdata),
        .reqFetchReady(fetchReady), .rspFetchValid(fetchRspValid), .rspFetchRdata(fetchRdata),
        .reqLsuReady(lsuReady), .rspLsuValid(lsuRspValid), .rspLsuRdata(lsuRdata),
        .reqHostReady(hostReady), .rspHostValid(hostRspValid), .rspHostRdata(hostRdata)
    );

endmodule

// ==== verification/socTb.sv ====
`include "core_settings.svh"

module socTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam string patternFile      = "verification/programPatterns.txt";
    localparam int    cyclesPerRetire  = 12;
    localparam int    cyclesPerPreload = 4;
    localparam int    cycleMargin      = 200;

    // Word used by the store and load program
    localparam logic [`XLEN-1:0] storeAddr = 32'h0000_0ff8;

    logic             iClk;
    logic             rstN;
    logic             run;
    logic             hostValid;
    logic             hostWrite;
    logic [`XLEN-1:0] hostAddr;
    logic [`XLEN-1:0] hostWdata;
    logic             hostReady;
    logic             hostRspValid;
    logic [`XLEN-1:0] hostRdata;
    logic             retireValid;
    logic [`XLEN-1:0] retirePc;
    logic [`XLEN-1:0] retireData;

    // Tables read from the pattern file
    logic [`XLEN-1:0] preloadAddrQ [$];
    logic [`XLEN-1:0] preloadDataQ [$];
    logic [`XLEN-1:0] retirePcQ [$];
    logic [`XLEN-1:0] retireDataQ [$];
    logic [`XLEN-1:0] finalAddrQ [$];
    logic [`XLEN-1:0] finalDataQ [$];

    bit patternsLoaded = 1'b0;
    bit runStarted     = 1'b0;
    int retireCount    = 0;

    socTop dut (
        .iClk(iClk), .rstN(rstN), .run(run),
        .hostValid(hostValid), .hostWrite(hostWrite),
        .hostAddr(hostAddr), .hostWdata(hostWdata),
        .hostReady(hostReady), .hostRspValid(hostRspValid), .hostRdata(hostRdata),
        .retireValid(retireValid), .retirePc(retirePc), .retireData(retireData)
    );

    // 20 ns clock
    initial begin
        iClk = 1'b0;
        forever #10 iClk = ~iClk;
    end

    ////////////////////////////////////////////////////////////
    // Error reporting and checks
    ////////////////////////////////////////////////////////////

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkWord(input string name, input logic [`XLEN-1:0] expected,
                             input logic [`XLEN-1:0] actual);
        assert (actual === expected)
        else failRun($sformatf("FAIL %s expected 0x%08h got 0x%08h", name, expected, actual));
    endtask

    // Nothing may retire or answer the host while idle
    task automatic checkIdle();
        checkWord("retireValid", `XLEN'(0), `XLEN'(retireValid));
        checkWord("hostRspValid", `XLEN'(0), `XLEN'(hostRspValid));
    endtask

    ////////////////////////////////////////////////////////////
    // Pattern file
    ////////////////////////////////////////////////////////////

    task automatic loadPatterns();
        int               fd;
        int               count;
        string            line;
        string            tag;
        logic [`XLEN-1:0] first;
        logic [`XLEN-1:0] second;
        fd = $fopen(patternFile, "r");
        if (fd == 0) failRun("could not open the pattern file");
        while ($fgets(line, fd) != 0) begin
            count = $sscanf(line, "%s %h %h", tag, first, second);
            // Comment lines and blank lines fall through here
            if (count == 3) begin
                if (tag == "P") begin
                    assert (first[`XLEN-1:`MEM_ADDR_BITS+2] == '0)
                    else failRun("a preload address lies outside the shared memory");
                    preloadAddrQ.push_back(first);
                    preloadDataQ.push_back(second);
                end else if (tag == "R") begin
                    retirePcQ.push_back(first);
                    retireDataQ.push_back(second);
                end else if (tag == "M") begin
                    finalAddrQ.push_back(first);
                    finalDataQ.push_back(second);
                end
            end
        end
        $fclose(fd);
        if (preloadAddrQ.size() == 0 || retirePcQ.size() == 0) begin
            failRun("the pattern file holds no program or no retire trace");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Host port access
    ////////////////////////////////////////////////////////////

    // One request, held until granted, drives on the falling edge
    task automatic hostAccess(input logic isWrite, input logic [`XLEN-1:0] addr,
                              input logic [`XLEN-1:0] wdata, output logic [`XLEN-1:0] rdata);
        logic granted;
        granted = 1'b0;
        rdata   = '0;
        @(negedge iClk);
        hostValid = 1'b1;
        hostWrite = isWrite;
        hostAddr  = addr;
        hostWdata = wdata;
        while (!granted) begin
            #1;
            granted = hostReady;
            @(negedge iClk);
        end
        // Transfer happened at the rising edge just passed
        hostValid = 1'b0;
        hostWrite = 1'b0;
        #1;
        if (isWrite) begin
            assert (hostRspValid === 1'b0)
            else failRun("a host write got a read response");
        end else begin
            assert (hostRspValid === 1'b1)
            else failRun("a host read got no response in the cycle after its transfer");
            rdata = hostRdata;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Store and load program, run from a fresh reset
    ////////////////////////////////////////////////////////////

    // lui x1,1 / addi x2,x0,-0x5a5 / sw x2,-8(x1) / lw x3,-8(x1) / jal x0,0
    task automatic runStoreLoadProgram();
        logic [`XLEN-1:0] code [5];
        logic [`XLEN-1:0] expData [5];
        logic [`XLEN-1:0] readWord;
        code    = '{32'h000010b7, 32'ha5b00113, 32'hfe20ac23, 32'hff80a183, 32'h0000006f};
        // Stores retire with their effective address, like branches with their ALU result
        expData = '{32'h0000_1000, 32'hffff_fa5b, storeAddr, 32'hffff_fa5b, 32'h0000_0014};
        @(negedge iClk);
        rstN       = 1'b0;
        runStarted = 1'b0;
        repeat (2) @(negedge iClk);
        rstN = 1'b1;
        // Overwrite the start of the program while the core idles
        foreach (code[i]) begin
            hostAccess(1'b1, `XLEN'(4 * i), code[i], readWord);
            retirePcQ.push_back(`XLEN'(4 * i));
            retireDataQ.push_back(expData[i]);
        end
        @(negedge iClk);
        run        = 1'b1;
        runStarted = 1'b1;
        while (retireCount < retirePcQ.size()) begin
            @(negedge iClk);
        end
        @(negedge iClk);
        run = 1'b0;
        // Stored word must be visible to the host too
        hostAccess(1'b0, storeAddr, '0, readWord);
        checkWord("hostRdata", expData[1], readWord);
    endtask

    ////////////////////////////////////////////////////////////
    // Retire trace monitor
    ////////////////////////////////////////////////////////////

    initial begin : retireMonitor
        int idx;
        forever begin
            @(negedge iClk);
            #1;
            if (rstN === 1'b1 && retireValid === 1'b1) begin
                if (!runStarted) failRun("an instruction retired before run was raised");
                if (retireCount < retirePcQ.size()) begin
                    idx = retireCount;
                    retireCount++;
                end else begin
                    // Past the end only the closing self-jump may retire
                    idx = retirePcQ.size() - 1;
                end
                checkWord("retirePc", retirePcQ[idx], retirePc);
                checkWord("retireData", retireDataQ[idx], retireData);
            end
        end
    end

    // Budget scales with the trace and the preload
    initial begin : watchdog
        int limit;
        wait (patternsLoaded);
        limit = retirePcQ.size() * cyclesPerRetire + preloadAddrQ.size() * cyclesPerPreload
                + cycleMargin;
        repeat (limit) @(posedge iClk);
        failRun($sformatf("the run did not finish within %0d cycles", limit));
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin : mainFlow
        logic [`XLEN-1:0] readWord;
        int               gap;
        int               pick;
        rstN      = 1'b0;
        run       = 1'b0;
        hostValid = 1'b0;
        hostWrite = 1'b0;
        hostAddr  = '0;
        hostWdata = '0;
        void'($urandom(32'hcfda3718));
        loadPatterns();
        patternsLoaded = 1'b1;

        // Reset over two rising edges
        @(negedge iClk);
        #1;
        checkIdle();
        @(negedge iClk);
        rstN = 1'b1;
        repeat (3) begin
            @(negedge iClk);
            #1;
            checkIdle();
        end

        // Program and data load, then read back every word
        foreach (preloadAddrQ[i]) begin
            hostAccess(1'b1, preloadAddrQ[i], preloadDataQ[i], readWord);
        end
        foreach (preloadAddrQ[i]) begin
            hostAccess(1'b0, preloadAddrQ[i], '0, readWord);
            checkWord("hostRdata", preloadDataQ[i], readWord);
        end

        @(negedge iClk);
        run        = 1'b1;
        runStarted = 1'b1;

        // Host reads at random gaps compete with fetch
        while (retireCount < retirePcQ.size()) begin
            gap = $urandom_range(5, 0);
            repeat (gap) @(negedge iClk);
            if (retireCount < retirePcQ.size()) begin
                pick = $urandom_range(preloadAddrQ.size() - 1, 0);
                hostAccess(1'b0, preloadAddrQ[pick], '0, readWord);
                checkWord("hostRdata", preloadDataQ[pick], readWord);
            end
        end

        @(negedge iClk);
        run = 1'b0;

        // Final memory image
        foreach (finalAddrQ[i]) begin
            hostAccess(1'b0, finalAddrQ[i], '0, readWord);
            checkWord("hostRdata", finalDataQ[i], readWord);
        end

        runStoreLoadProgram();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== verification/programPatterns.txt ====
# Columns: kind, byte address (hex), word (hex)
# Kinds: P preload word, R retire pc and retire data in order, M final memory word
P 00000000 00500093
P 00000004 ffd00113
P 00000008 002081b3
P 0000000c 40208233
P 00000010 0020f2b3
P 00000014 0020e333
P 00000018 0020c3b3
P 0000001c 00112433
P 00000020 0030a493
P 00000024 0f017513
P 00000028 7000e593
P 0000002c fff14613
P 00000030 123456b7
P 00000034 00708013
P 00000038 00100733
P 0000003c 00108463
# Slots holding 06300793 are skipped by branches and jumps
P 00000040 06300793
P 00000044 00109463
P 00000048 00209463
P 0000004c 06300793
P 00000050 00208463
P 00000054 00c0086f
P 00000058 06300793
P 0000005c 06300793
P 00000060 010808e7
P 00000064 06300793
P 00000068 01180933
P 0000006c 970589e7
P 00000070 06300793
P 00000074 00098a33
P 00000078 0000006f
P 00000800 a5c30f96
P 00000ffc 5a3cf069
R 00000000 00000005
R 00000004 fffffffd
R 00000008 00000002
R 0000000c 00000008
R 00000010 00000005
R 00000014 fffffffd
R 00000018 fffffff8
R 0000001c 00000001
R 00000020 00000000
R 00000024 000000f0
R 00000028 00000705
R 0000002c 00000002
R 00000030 12345000
R 00000034 0000000c
R 00000038 00000005
R 0000003c 00000000
R 00000044 00000000
R 00000048 00000008
R 00000050 00000008
R 00000054 00000058
R 00000060 00000064
R 00000068 000000bc
R 0000006c 00000070
R 00000074 00000070
R 00000078 0000007c
M 00000000 00500093
M 0000003c 00108463
M 00000078 0000006f
M 00000800 a5c30f96
M 00000ffc 5a3cf069

// ==== verilog.f ====
+incdir+common
common/rvIsaPkg.sv
common/memBusPkg.sv
core/instructionDecoder.sv
core/registerFile.sv
core/executeUnit.sv
core/fetchSequencer.sv
core/loadStoreUnit.sv
src/sharedMemory.sv
src/socTop.sv
verification/socTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module socTb -f verilog.f -o socTbSim

status=0
./obj_dir/socTbSim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "^TESTBENCH PASSED$" sim.log; then
    exit 0
fi
echo "Simulation did not pass (exit status $status), see sim.log"
exit 1
